// ==== include/roce_rx_settings.svh ====
`ifndef ROCE_RX_SETTINGS_SVH
`define ROCE_RX_SETTINGS_SVH

// payload word width in bits
`define ROCE_DATA_WIDTH 256

// RoCE v2 well known udp destination port
`define ROCE_UDP_PORT 16'h12B7

// RC acknowledge opcode
`define ROCE_OP_RC_ACK 8'h11

// descriptor fifo entries, power of two
`define ROCE_ACK_FIFO_DEPTH 4

// width of the drop counters
`define ROCE_CNT_WIDTH 16

`endif

// ==== src/udp_ip_pkg.sv ====
`include "roce_rx_settings.svh"

package udp_ip_pkg;

  // bytes per payload word
  localparam int DATA_BYTES = `ROCE_DATA_WIDTH / 8;

  // parallel header from the udp/ip receiver
  // only the fields the ack path needs
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] udp_src_port;
    logic [15:0] udp_dst_port;
    logic [15:0] udp_length;
    // icrc computed upstream over the whole frame
    logic [31:0] computed_icrc;
  } udp_rx_hdr_t;

  // one beat of the payload stream
  // byte 0 in the lowest lane
  typedef struct packed {
    logic [`ROCE_DATA_WIDTH-1:0] tdata;
    logic [DATA_BYTES-1:0]       tkeep;
    // end of frame
    logic                        tlast;
    // upstream error mark
    logic                        tuser;
  } axis_word_t;

endpackage

// ==== src/roce_proto_pkg.sv ====
package roce_proto_pkg;

  // base transport header
  // solicited event, mig req, pad count, version and reserved bits not kept
  typedef struct packed {
    logic [7:0]  opcode;
    logic [15:0] p_key;
    logic [23:0] dest_qp;
    logic        ack_req;
    logic [23:0] psn;
  } roce_bth_t;

  // ack extended transport header
  typedef struct packed {
    // ack / nak code and credit count
    logic [7:0]  syndrome;
    logic [23:0] msn;
  } roce_aeth_t;

  // descriptor handed to the sink for every good ack
  typedef struct packed {
    roce_bth_t   bth;
    roce_aeth_t  aeth;
    // source ip of the responder
    logic [31:0] src_ip;
  } roce_ack_t;

  // receive fsm states
  typedef enum logic [1:0] {
    // waiting for a header
    ST_IDLE       = 2'd0,
    // first payload word carries bth, aeth and icrc
    ST_READ_FIRST = 2'd1,
    // compare icrc, offer descriptor
    ST_CHECK_ICRC = 2'd2,
    // drain words up to tlast
    ST_WAIT_LAST  = 2'd3
  } rx_state_t;

endpackage

// ==== src/roce_bth_aeth_decode.sv ====
`timescale 1ns/1ps
`include "roce_rx_settings.svh"

module roce_bth_aeth_decode (
  input  logic [`ROCE_DATA_WIDTH-1:0] word,
  output roce_proto_pkg::roce_bth_t   bth,
  output roce_proto_pkg::roce_aeth_t  aeth,
  output logic [31:0]                 rx_icrc
);

  // byte n of the word, byte 0 in the lowest lane
  function automatic logic [7:0] lane(input int n);
    return word[8*n +: 8];
  endfunction

  always_comb begin
    // byte 0
    bth.opcode  = lane(0);
    // byte 1 holds se, migreq, pad and version, skipped
    // multi-byte fields come msb first
    bth.p_key   = {lane(2), lane(3)};
    // byte 4 reserved
    bth.dest_qp = {lane(5), lane(6), lane(7)};
    // top bit of byte 8, rest reserved
    bth.ack_req = word[71];
    bth.psn     = {lane(9), lane(10), lane(11)};
  end

  always_comb begin
    // aeth follows the 12 byte bth
    aeth.syndrome = lane(12);
    aeth.msn      = {lane(13), lane(14), lane(15)};
  end

  // ack has no payload so icrc sits right behind the aeth
  assign rx_icrc = {lane(16), lane(17), lane(18), lane(19)};

endmodule

// ==== src/roce_ack_rx_fsm.sv ====
`timescale 1ns/1ps
`include "roce_rx_settings.svh"

module roce_ack_rx_fsm #(
  parameter bit ENABLE_ICRC_CHECK = 1'b1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        s_hdr_valid,
  output logic                        s_hdr_ready,
  input  udp_ip_pkg::udp_rx_hdr_t     s_hdr,
  input  logic                        s_payload_valid,
  output logic                        s_payload_ready,
  input  udp_ip_pkg::axis_word_t      s_payload,
  output logic                        push_valid,
  input  logic                        push_ready,
  output roce_proto_pkg::roce_ack_t   push_desc,
  output logic                        busy,
  output logic [`ROCE_CNT_WIDTH-1:0]  drop_count,
  output logic [`ROCE_CNT_WIDTH-1:0]  icrc_error_count
);
  import udp_ip_pkg::*;
  import roce_proto_pkg::*;

  localparam int CW = `ROCE_CNT_WIDTH;

  rx_state_t   state;
  rx_state_t   state_next;

  // captured header and first word fields
  udp_rx_hdr_t hdr_q;
  roce_bth_t   bth_dec;
  roce_bth_t   bth_q;
  roce_aeth_t  aeth_dec;
  roce_aeth_t  aeth_q;
  logic [31:0] icrc_dec;
  logic [31:0] icrc_q;

  // frame passed the opcode and port filter
  logic        keep_q;

  logic        hdr_fire;
  logic        word_fire;
  logic        first_fire;
  logic        first_keep;
  logic        icrc_ok;
  logic        drop_inc;
  logic        icrc_err_inc;

  roce_bth_aeth_decode i_decode (
    .word    (s_payload.tdata),
    .bth     (bth_dec),
    .aeth    (aeth_dec),
    .rx_icrc (icrc_dec)
  );

  assign hdr_fire   = s_hdr_valid && s_hdr_ready;
  assign word_fire  = s_payload_valid && s_payload_ready;
  assign first_fire = word_fire && (state == ST_READ_FIRST);

  // only rc acks on the roce port are kept
  assign first_keep = (bth_dec.opcode == `ROCE_OP_RC_ACK) &&
                      (hdr_q.udp_dst_port == `ROCE_UDP_PORT);

  // check switched off means every kept frame is good
  assign icrc_ok = !ENABLE_ICRC_CHECK || (hdr_q.computed_icrc == icrc_q);

  assign push_desc = '{bth: bth_q, aeth: aeth_q, src_ip: hdr_q.src_ip};

  always_comb begin
    state_next   = state;
    push_valid   = 1'b0;
    drop_inc     = 1'b0;
    icrc_err_inc = 1'b0;
    case (state)
      ST_IDLE: begin
        if (hdr_fire) begin
          state_next = ST_READ_FIRST;
        end
      end
      ST_READ_FIRST: begin
        if (word_fire) begin
          // non ack or wrong port counts once per frame
          drop_inc = !first_keep;
          if (!s_payload.tlast) begin
            state_next = ST_WAIT_LAST;
          end else if (first_keep) begin
            state_next = ST_CHECK_ICRC;
          end else begin
            state_next = ST_IDLE;
          end
        end
      end
      ST_WAIT_LAST: begin
        // rest of frame thrown away, kept frames still checked after
        if (word_fire && s_payload.tlast) begin
          state_next = keep_q ? ST_CHECK_ICRC : ST_IDLE;
        end
      end
      ST_CHECK_ICRC: begin
        if (icrc_ok) begin
          // hold here while the fifo is full
          push_valid = 1'b1;
          if (push_ready) begin
            state_next = ST_IDLE;
          end
        end else begin
          icrc_err_inc = 1'b1;
          state_next   = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= ST_IDLE;
      s_hdr_ready      <= 1'b0;
      s_payload_ready  <= 1'b0;
      busy             <= 1'b0;
      keep_q           <= 1'b0;
      drop_count       <= '0;
      icrc_error_count <= '0;
    end else begin
      state           <= state_next;
      // readies registered from the next state, so they line up with it
      s_hdr_ready     <= (state_next == ST_IDLE);
      s_payload_ready <= (state_next == ST_READ_FIRST) || (state_next == ST_WAIT_LAST);
      busy            <= (state_next != ST_IDLE);
      if (first_fire) begin
        keep_q <= first_keep;
      end
      if (drop_inc) begin
        drop_count <= drop_count + CW'(1);
      end
      if (icrc_err_inc) begin
        icrc_error_count <= icrc_error_count + CW'(1);
      end
    end
  end

  // header and first word payload
  always_ff @(posedge clk) begin
    if (hdr_fire) begin
      hdr_q <= s_hdr;
    end
    if (first_fire) begin
      bth_q  <= bth_dec;
      aeth_q <= aeth_dec;
      icrc_q <= icrc_dec;
    end
  end

  // header side open only in idle, payload side only while reading
  // so the two never open together
  a_ready_excl: assert property (@(posedge clk) disable iff (rst)
    (!s_hdr_ready || (state == ST_IDLE)) &&
    (!s_payload_ready || (state == ST_READ_FIRST) || (state == ST_WAIT_LAST)));

  // stalled push keeps its descriptor until the fifo takes it
  a_push_hold: assert property (@(posedge clk) disable iff (rst)
    push_valid && !push_ready |=> push_valid && $stable(push_desc));

endmodule

// ==== src/roce_ack_fifo.sv ====
`timescale 1ns/1ps
`include "roce_rx_settings.svh"

module roce_ack_fifo #(
  parameter int DEPTH = `ROCE_ACK_FIFO_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push_valid,
  output logic                      push_ready,
  input  roce_proto_pkg::roce_ack_t push_desc,
  output logic                      m_ack_valid,
  input  logic                      m_ack_ready,
  output roce_proto_pkg::roce_ack_t m_ack
);
  import roce_proto_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  roce_ack_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // occupancy, 0 to DEPTH
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // back-pressure toward the fsm
  assign push_ready  = (count != CNT_W'(DEPTH));
  assign m_ack_valid = (count != '0);
  assign m_ack       = mem[rd_ptr];

  assign wr_en = push_valid && push_ready;
  assign rd_en = m_ack_valid && m_ack_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_desc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own, depth is a power of two
      if (wr_en) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // when full the write slot is the oldest entry
  // a write there would clobber the head
  a_no_write_full: assert property (@(posedge clk) disable iff (rst)
    (count == CNT_W'(DEPTH)) && !rd_en |=> $stable(m_ack));

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(DEPTH));

endmodule

// ==== src/roce_ack_rx.sv ====
`timescale 1ns/1ps
`include "roce_rx_settings.svh"

module roce_ack_rx #(
  parameter bit ENABLE_ICRC_CHECK = 1'b1
) (
  input  logic                        clk,
  input  logic                        rst,
  // udp/ip header in
  input  logic                        s_hdr_valid,
  output logic                        s_hdr_ready,
  input  udp_ip_pkg::udp_rx_hdr_t     s_hdr,
  // payload stream in
  input  logic                        s_payload_valid,
  output logic                        s_payload_ready,
  input  udp_ip_pkg::axis_word_t      s_payload,
  // ack descriptors out
  output logic                        m_ack_valid,
  input  logic                        m_ack_ready,
  output roce_proto_pkg::roce_ack_t   m_ack,
  // status
  output logic                        busy,
  output logic [`ROCE_CNT_WIDTH-1:0]  drop_count,
  output logic [`ROCE_CNT_WIDTH-1:0]  icrc_error_count
);
  import roce_proto_pkg::*;

  // fsm to fifo
  logic      push_valid;
  logic      push_ready;
  roce_ack_t push_desc;

  roce_ack_rx_fsm #(
    .ENABLE_ICRC_CHECK (ENABLE_ICRC_CHECK)
  ) i_fsm (
    .clk              (clk),
    .rst              (rst),
    .s_hdr_valid      (s_hdr_valid),
    .s_hdr_ready      (s_hdr_ready),
    .s_hdr            (s_hdr),
    .s_payload_valid  (s_payload_valid),
    .s_payload_ready  (s_payload_ready),
    .s_payload        (s_payload),
    .push_valid       (push_valid),
    .push_ready       (push_ready),
    .push_desc        (push_desc),
    .busy             (busy),
    .drop_count       (drop_count),
    .icrc_error_count (icrc_error_count)
  );

  // descriptor buffer, full stalls the fsm in its check state
  roce_ack_fifo i_fifo (
    .clk         (clk),
    .rst         (rst),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .push_desc   (push_desc),
    .m_ack_valid (m_ack_valid),
    .m_ack_ready (m_ack_ready),
    .m_ack       (m_ack)
  );

endmodule

// ==== verification/tb_roce_ack_rx.sv ====
`timescale 1ns/1ps
`include "roce_rx_settings.svh"

module tb_roce_ack_rx;
  import udp_ip_pkg::*;
  import roce_proto_pkg::*;

  localparam int DW = `ROCE_DATA_WIDTH;
  localparam int CW = `ROCE_CNT_WIDTH;
  // six tests, at most eight frames each, about 40 cycles per frame
  localparam int TIMEOUT_CYCLES = 2000;
  // per handshake wait
  localparam int WAIT_LIMIT = 100;

  logic            clk;
  logic            rst;
  logic            s_hdr_valid;
  logic            s_hdr_ready;
  udp_rx_hdr_t     s_hdr;
  logic            s_payload_valid;
  logic            s_payload_ready;
  axis_word_t      s_payload;
  logic            m_ack_valid;
  logic            m_ack_ready;
  roce_ack_t       m_ack;
  logic            busy;
  logic [CW-1:0]   drop_count;
  logic [CW-1:0]   icrc_error_count;

  int cycle_count = 0;
  int error_count = 0;

  roce_ack_rx i_dut (
    .clk              (clk),
    .rst              (rst),
    .s_hdr_valid      (s_hdr_valid),
    .s_hdr_ready      (s_hdr_ready),
    .s_hdr            (s_hdr),
    .s_payload_valid  (s_payload_valid),
    .s_payload_ready  (s_payload_ready),
    .s_payload        (s_payload),
    .m_ack_valid      (m_ack_valid),
    .m_ack_ready      (m_ack_ready),
    .m_ack            (m_ack),
    .busy             (busy),
    .drop_count       (drop_count),
    .icrc_error_count (icrc_error_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string test, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    error_count++;
    $display("CHECK FAILED %s: %s expected %0h actual %0h", test, what, exp, act);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_error(input string test, input string msg);
    error_count++;
    $display("%s: %s", test, msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else report_mismatch(test, what, exp, act);
  endtask

  // ack with random fields, opcode fixed to rc ack
  function automatic roce_ack_t random_ack(input logic [31:0] src_ip);
    roce_ack_t   d;
    logic [31:0] r;
    r = $urandom();
    d.bth.opcode  = `ROCE_OP_RC_ACK;
    d.bth.p_key   = r[15:0];
    r = $urandom();
    d.bth.dest_qp = r[23:0];
    d.bth.ack_req = r[31];
    r = $urandom();
    d.bth.psn     = r[23:0];
    d.aeth.syndrome = r[31:24];
    r = $urandom();
    d.aeth.msn    = r[23:0];
    d.src_ip      = src_ip;
    return d;
  endfunction

  function automatic udp_rx_hdr_t make_hdr(input logic [31:0] src_ip,
                                           input logic [15:0] dst_port,
                                           input logic [31:0] icrc);
    udp_rx_hdr_t h;
    h.src_ip        = src_ip;
    h.dst_ip        = 32'h0a00_0001;
    h.udp_src_port  = 16'hc000;
    h.udp_dst_port  = dst_port;
    h.udp_length    = 16'd28;
    h.computed_icrc = icrc;
    return h;
  endfunction

  // byte 0 lowest lane, multi-byte fields msb first
  function automatic logic [DW-1:0] first_word(input roce_ack_t d, input logic [31:0] icrc);
    logic [DW-1:0] w;
    w = '0;
    w[0*8 +: 8]  = d.bth.opcode;
    w[2*8 +: 8]  = d.bth.p_key[15:8];
    w[3*8 +: 8]  = d.bth.p_key[7:0];
    w[5*8 +: 8]  = d.bth.dest_qp[23:16];
    w[6*8 +: 8]  = d.bth.dest_qp[15:8];
    w[7*8 +: 8]  = d.bth.dest_qp[7:0];
    // ack request is bit 7 of byte 8
    w[8*8 + 7]   = d.bth.ack_req;
    w[9*8 +: 8]  = d.bth.psn[23:16];
    w[10*8 +: 8] = d.bth.psn[15:8];
    w[11*8 +: 8] = d.bth.psn[7:0];
    w[12*8 +: 8] = d.aeth.syndrome;
    w[13*8 +: 8] = d.aeth.msn[23:16];
    w[14*8 +: 8] = d.aeth.msn[15:8];
    w[15*8 +: 8] = d.aeth.msn[7:0];
    w[16*8 +: 8] = icrc[31:24];
    w[17*8 +: 8] = icrc[23:16];
    w[18*8 +: 8] = icrc[15:8];
    w[19*8 +: 8] = icrc[7:0];
    return w;
  endfunction

  // all handshake tasks start and end on a falling edge
  task automatic send_hdr(input udp_rx_hdr_t hdr);
    int waited;
    waited = 0;
    s_hdr       = hdr;
    s_hdr_valid = 1'b1;
    while (!s_hdr_ready) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_error("send_hdr", "header was never accepted");
    end
    @(negedge clk);
    s_hdr_valid = 1'b0;
  endtask

  task automatic send_word(input axis_word_t word);
    int waited;
    waited = 0;
    s_payload       = word;
    s_payload_valid = 1'b1;
    while (!s_payload_ready) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_error("send_word", "payload word was never accepted");
    end
    @(negedge clk);
    s_payload_valid = 1'b0;
  endtask

  // header, then first word, then random filler up to tlast
  task automatic send_frame(input udp_rx_hdr_t hdr, input logic [DW-1:0] first, input int nwords);
    axis_word_t word;
    send_hdr(hdr);
    for (int i = 0; i < nwords; i++) begin
      word.tdata = first;
      if (i > 0) begin
        for (int j = 0; j < DW / 32; j++) begin
          word.tdata[32*j +: 32] = $urandom();
        end
      end
      word.tkeep = '1;
      word.tlast = (i == nwords - 1);
      word.tuser = 1'b0;
      send_word(word);
    end
  endtask

  task automatic wait_idle(input string test);
    int waited;
    waited = 0;
    while (!s_hdr_ready) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_error(test, "receiver never went back to idle");
    end
  endtask

  // wait for a descriptor, compare every field, then take it
  task automatic expect_ack(input string test, input roce_ack_t exp);
    int waited;
    waited = 0;
    while (!m_ack_valid) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_error(test, "expected acknowledge never arrived");
    end
    check_value(test, "opcode", 64'(exp.bth.opcode), 64'(m_ack.bth.opcode));
    check_value(test, "p_key", 64'(exp.bth.p_key), 64'(m_ack.bth.p_key));
    check_value(test, "dest_qp", 64'(exp.bth.dest_qp), 64'(m_ack.bth.dest_qp));
    check_value(test, "ack_req", 64'(exp.bth.ack_req), 64'(m_ack.bth.ack_req));
    check_value(test, "psn", 64'(exp.bth.psn), 64'(m_ack.bth.psn));
    check_value(test, "syndrome", 64'(exp.aeth.syndrome), 64'(m_ack.aeth.syndrome));
    check_value(test, "msn", 64'(exp.aeth.msn), 64'(m_ack.aeth.msn));
    check_value(test, "src_ip", 64'(exp.src_ip), 64'(m_ack.src_ip));
    m_ack_ready = 1'b1;
    @(negedge clk);
    m_ack_ready = 1'b0;
  endtask

  // fifo output follows the push edge, so idle means any ack is visible
  task automatic expect_no_ack(input string test);
    wait_idle(test);
    assert (!m_ack_valid) else report_error(test, "acknowledge arrived where none was expected");
  endtask

  task automatic test_single_ack();
    roce_ack_t   d;
    logic [31:0] icrc;
    d    = random_ack(32'hc0a8_0102);
    icrc = $urandom();
    send_frame(make_hdr(d.src_ip, `ROCE_UDP_PORT, icrc), first_word(d, icrc), 1);
    expect_ack("single_ack", d);
    expect_no_ack("single_ack");
  endtask

  task automatic test_wrong_opcode();
    roce_ack_t     d;
    logic [31:0]   icrc;
    logic [CW-1:0] drops;
    drops = drop_count;
    d     = random_ack(32'hc0a8_0103);
    // rdma write only
    d.bth.opcode = 8'h0a;
    icrc  = $urandom();
    send_frame(make_hdr(d.src_ip, `ROCE_UDP_PORT, icrc), first_word(d, icrc), 1);
    expect_no_ack("wrong_opcode");
    check_value("wrong_opcode", "drop_count", 64'(drops + CW'(1)), 64'(drop_count));
  endtask

  task automatic test_wrong_port();
    roce_ack_t     d;
    logic [31:0]   icrc;
    logic [CW-1:0] drops;
    drops = drop_count;
    d     = random_ack(32'hc0a8_0104);
    icrc  = $urandom();
    send_frame(make_hdr(d.src_ip, 16'h12b8, icrc), first_word(d, icrc), 1);
    expect_no_ack("wrong_port");
    check_value("wrong_port", "drop_count", 64'(drops + CW'(1)), 64'(drop_count));
  endtask

  task automatic test_icrc_error();
    roce_ack_t     d;
    logic [31:0]   icrc;
    logic [CW-1:0] errs;
    logic [CW-1:0] drops;
    errs  = icrc_error_count;
    drops = drop_count;
    d     = random_ack(32'hc0a8_0105);
    icrc  = $urandom();
    // one flipped bit in the upstream value
    send_frame(make_hdr(d.src_ip, `ROCE_UDP_PORT, icrc ^ 32'h0000_0100), first_word(d, icrc), 1);
    expect_no_ack("icrc_error");
    check_value("icrc_error", "icrc_error_count", 64'(errs + CW'(1)), 64'(icrc_error_count));
    check_value("icrc_error", "drop_count", 64'(drops), 64'(drop_count));
  endtask

  task automatic test_multi_word();
    roce_ack_t     d;
    logic [31:0]   icrc;
    logic [CW-1:0] drops;
    d    = random_ack(32'hc0a8_0106);
    icrc = $urandom();
    send_frame(make_hdr(d.src_ip, `ROCE_UDP_PORT, icrc), first_word(d, icrc), 3);
    expect_ack("multi_word", d);
    expect_no_ack("multi_word");
    // dropped three word frame, then a normal ack
    drops = drop_count;
    d     = random_ack(32'hc0a8_0107);
    d.bth.opcode = 8'h0a;
    send_frame(make_hdr(d.src_ip, `ROCE_UDP_PORT, icrc), first_word(d, icrc), 3);
    expect_no_ack("multi_word");
    check_value("multi_word", "drop_count", 64'(drops + CW'(1)), 64'(drop_count));
    d    = random_ack(32'hc0a8_0108);
    icrc = $urandom();
    send_frame(make_hdr(d.src_ip, `ROCE_UDP_PORT, icrc), first_word(d, icrc), 1);
    expect_ack("multi_word", d);
  endtask

  task automatic test_back_pressure();
    roce_ack_t   sent [6];
    logic [31:0] icrc [6];
    for (int i = 0; i < 6; i++) begin
      sent[i] = random_ack(32'hc0a8_0200 + 32'(i));
      icrc[i] = $urandom();
    end
    // four fill the fifo, the fifth stalls in the check state
    for (int i = 0; i < 5; i++) begin
      send_frame(make_hdr(sent[i].src_ip, `ROCE_UDP_PORT, icrc[i]),
                 first_word(sent[i], icrc[i]), 1);
    end
    repeat (10) begin
      @(negedge clk);
      assert (!s_hdr_ready && busy)
        else report_error("back_pressure", "header ready returned while the FIFO was full");
    end
    fork
      send_frame(make_hdr(sent[5].src_ip, `ROCE_UDP_PORT, icrc[5]),
                 first_word(sent[5], icrc[5]), 1);
      for (int i = 0; i < 6; i++) begin
        expect_ack("back_pressure", sent[i]);
      end
    join
    expect_no_ack("back_pressure");
  endtask

  initial begin
    void'($urandom(32'ha0a4));
    rst             = 1'b1;
    s_hdr_valid     = 1'b0;
    s_hdr           = '0;
    s_payload_valid = 1'b0;
    s_payload       = '0;
    m_ack_ready     = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    // outputs quiet while in reset
    check_value("reset", "s_hdr_ready", 64'(0), 64'(s_hdr_ready));
    check_value("reset", "s_payload_ready", 64'(0), 64'(s_payload_ready));
    check_value("reset", "m_ack_valid", 64'(0), 64'(m_ack_valid));
    check_value("reset", "busy", 64'(0), 64'(busy));
    check_value("reset", "drop_count", 64'(0), 64'(drop_count));
    check_value("reset", "icrc_error_count", 64'(0), 64'(icrc_error_count));
    rst = 1'b0;
    @(negedge clk);
    test_single_ack();
    test_wrong_opcode();
    test_wrong_port();
    test_icrc_error();
    test_multi_word();
    test_back_pressure();
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
src/udp_ip_pkg.sv
src/roce_proto_pkg.sv
src/roce_bth_aeth_decode.sv
src/roce_ack_rx_fsm.sv
src/roce_ack_fifo.sv
src/roce_ack_rx.sv
verification/tb_roce_ack_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_roce_ack_rx -o sim_tb
status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation passed"
